//--- hdl/snake_pkg.sv
`default_nettype none

package snake_pkg;

	////////////////////////////// grid and play
	localparam int GRID_W = 32;                    // columns, border included
	localparam int GRID_H = 24;                    // rows, border included

	typedef logic [4:0] coord_x_t;                 // column number
	typedef logic [4:0] coord_y_t;                 // row number

	localparam int MAX_LEN = 16;                   // body array depth
	typedef logic [4:0] len_t;                     // holds 0..MAX_LEN

	localparam len_t     START_LEN = 5'd3;         // length after restart
	localparam coord_x_t START_X   = 5'd8;         // head column after restart
	localparam coord_y_t START_Y   = 5'd8;         // head row after restart

	localparam coord_x_t APPLE_X0     = 5'd20;     // first apple
	localparam coord_y_t APPLE_Y0     = 5'd8;
	localparam int       APPLE_STEP_X = 7;         // placement stride in x
	localparam int       APPLE_STEP_Y = 5;         // placement stride in y

	typedef logic [7:0] score_t;

	////////////////////////////// timing
	localparam int MOVE_PERIOD = 64;               // clk cycles per move tick
	localparam int PS2_FILTER  = 8;                // ps2 clock filter samples

	////////////////////////////// directions and scan codes
	typedef enum logic [1:0]
	{
		DIR_RIGHT = 2'd0,
		DIR_UP    = 2'd1,
		DIR_LEFT  = 2'd2,
		DIR_DOWN  = 2'd3                           // opposite is always dir ^ 2
	} dir_t;

	localparam logic [7:0] KEY_UP    = 8'h75;
	localparam logic [7:0] KEY_LEFT  = 8'h6B;
	localparam logic [7:0] KEY_DOWN  = 8'h72;
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	localparam logic [7:0] KEY_SPACE = 8'h29;
	localparam logic [7:0] KEY_BREAK = 8'hF0;      // release prefix
	localparam logic [7:0] KEY_EXT   = 8'hE0;      // extended key prefix

endpackage

`default_nettype wire

//--- hdl/ps2_rx.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_rx import snake_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       ps2c,                      // keyboard clock, raw
	input  logic       ps2d,                      // keyboard data, raw
	output logic [7:0] rx_data,                   // valid with rx_valid
	output logic       rx_valid                   // one cycle per frame
);

	typedef enum logic {ST_IDLE, ST_RX} state_t;

	state_t                  state;
	logic [PS2_FILTER-1:0]   filter_reg;          // ps2c history
	logic                    f_val;               // filtered ps2c
	logic                    f_val_next;
	logic                    neg_edge;
	logic [3:0]              bit_cnt;             // bits left in frame
	logic [9:0]              shreg;               // data, parity, stop

	////////////////////////////// clock filter
	// the level only changes once every sample in the window agrees
	always_comb
	begin
		if (&filter_reg)
			f_val_next = 1'b1;
		else if (~|filter_reg)
			f_val_next = 1'b0;
		else
			f_val_next = f_val;                   // mixed, hold
	end

	assign neg_edge = f_val & ~f_val_next;        // filtered high to low

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			filter_reg <= '1;                     // bus idles high
			f_val      <= 1'b1;
		end
		else
		begin
			filter_reg <= {ps2c, filter_reg[PS2_FILTER-1:1]};
			f_val      <= f_val_next;
		end
	end

	////////////////////////////// frame FSM
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state    <= ST_IDLE;
			bit_cnt  <= 4'd0;
			rx_valid <= 1'b0;
		end
		else
		begin
			rx_valid <= 1'b0;                     // pulse by default
			case (state)
				ST_IDLE:
				begin
					if (neg_edge)                 // start bit edge
					begin
						bit_cnt <= 4'd10;         // 8 data + parity + stop
						state   <= ST_RX;
					end
				end
				ST_RX:
				begin
					if (neg_edge)
						bit_cnt <= bit_cnt - 4'd1;
					if (bit_cnt == 4'd0)          // whole frame in
					begin
						rx_valid <= 1'b1;
						state    <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// lsb first, so the first data bit ends in bit 0 after ten shifts
	always_ff @(posedge clk)
	begin
		if (state == ST_RX && neg_edge)
			shreg <= {ps2d, shreg[9:1]};
	end

	assign rx_data = shreg[7:0];                  // parity and stop dropped

endmodule

`default_nettype wire

//--- hdl/key_decode.sv
`timescale 1ns/1ps
`default_nettype none

module key_decode import snake_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] rx_data,
	input  logic       rx_valid,
	output dir_t       dir,                       // pending move direction
	output logic       restart                    // one cycle on space press
);

	logic break_pend;                             // F0 seen, drop next byte
	logic is_arrow;
	dir_t key_dir;

	// arrow scan code to direction
	always_comb
	begin
		is_arrow = 1'b1;
		key_dir  = DIR_RIGHT;
		case (rx_data)
			KEY_UP:    key_dir = DIR_UP;
			KEY_LEFT:  key_dir = DIR_LEFT;
			KEY_DOWN:  key_dir = DIR_DOWN;
			KEY_RIGHT: key_dir = DIR_RIGHT;
			default:   is_arrow = 1'b0;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			break_pend <= 1'b0;
			dir        <= DIR_RIGHT;
			restart    <= 1'b0;
		end
		else
		begin
			restart <= 1'b0;
			if (rx_valid)
			begin
				if (rx_data == KEY_EXT)
					break_pend <= break_pend;     // prefix only, skip
				else if (rx_data == KEY_BREAK)
					break_pend <= 1'b1;
				else if (break_pend)
					break_pend <= 1'b0;           // release code, discard
				else if (rx_data == KEY_SPACE)
				begin
					restart <= 1'b1;
					dir     <= DIR_RIGHT;         // new game heads right
				end
				else if (is_arrow && key_dir != dir_t'(dir ^ 2'd2))
					dir <= key_dir;               // no reversal onto body
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/snake_engine.sv
`timescale 1ns/1ps
`default_nettype none

module snake_engine import snake_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  dir_t     dir,
	input  logic     restart,
	output coord_x_t head_x,
	output coord_y_t head_y,
	output logic     apple_eaten,                 // one cycle per apple
	output logic     game_over                    // level until restart
);

	logic [$clog2(MOVE_PERIOD)-1:0] move_cnt;
	logic     tick;
	coord_x_t body_x [MAX_LEN];                   // index 0 is the head
	coord_y_t body_y [MAX_LEN];
	len_t     len;
	coord_x_t apple_x;
	coord_y_t apple_y;
	coord_x_t next_x;
	coord_y_t next_y;
	logic     hit_border;
	logic     hit_body;
	logic     eat;

	// start layout, a horizontal line trailing left of the head
	function automatic coord_x_t init_x(int idx);
		int k;
		k = (idx < START_LEN) ? idx : START_LEN - 1;
		return coord_x_t'(START_X - k);
	endfunction

	////////////////////////////// move timer
	assign tick = (int'(move_cnt) == MOVE_PERIOD - 1);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			move_cnt <= '0;
		else if (restart || tick)
			move_cnt <= '0;                       // restart realigns ticks
		else
			move_cnt <= move_cnt + 1'b1;
	end

	////////////////////////////// next head and hits
	always_comb
	begin
		next_x = body_x[0];
		next_y = body_y[0];
		case (dir)
			DIR_RIGHT: next_x = body_x[0] + 5'd1;
			DIR_UP:    next_y = body_y[0] - 5'd1; // row 0 at top
			DIR_LEFT:  next_x = body_x[0] - 5'd1;
			DIR_DOWN:  next_y = body_y[0] + 5'd1;
			default:   next_x = body_x[0];
		endcase
	end

	assign hit_border = (next_x == 5'd0) || (int'(next_x) == GRID_W - 1) ||
		(next_y == 5'd0) || (int'(next_y) == GRID_H - 1);

	// the tail segment moves away this tick, so it is not compared
	always_comb
	begin
		hit_body = 1'b0;
		for (int i = 0; i < MAX_LEN; i++)
		begin
			if (i < int'(len) - 1 && body_x[i] == next_x && body_y[i] == next_y)
				hit_body = 1'b1;
		end
	end

	assign eat = (next_x == apple_x) && (next_y == apple_y);

	////////////////////////////// game state
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < MAX_LEN; i++)
			begin
				body_x[i] <= init_x(i);
				body_y[i] <= START_Y;
			end
			len         <= START_LEN;
			apple_x     <= APPLE_X0;
			apple_y     <= APPLE_Y0;
			apple_eaten <= 1'b0;
			game_over   <= 1'b0;
		end
		else if (restart)
		begin
			for (int i = 0; i < MAX_LEN; i++)
			begin
				body_x[i] <= init_x(i);
				body_y[i] <= START_Y;
			end
			len         <= START_LEN;
			apple_x     <= APPLE_X0;
			apple_y     <= APPLE_Y0;
			apple_eaten <= 1'b0;
			game_over   <= 1'b0;
		end
		else
		begin
			apple_eaten <= 1'b0;
			if (tick && !game_over)
			begin
				if (hit_border || hit_body)
					game_over <= 1'b1;            // freeze where we are
				else
				begin
					for (int i = MAX_LEN - 1; i > 0; i--)
					begin
						body_x[i] <= body_x[i-1];
						body_y[i] <= body_y[i-1];
					end
					body_x[0] <= next_x;
					body_y[0] <= next_y;
					if (eat)
					begin
						apple_eaten <= 1'b1;
						if (int'(len) < MAX_LEN)
							len <= len + 5'd1;
						// stride inside the playfield, 1 .. size-2
						apple_x <= coord_x_t'((int'(apple_x) - 1 + APPLE_STEP_X) %
							(GRID_W - 2) + 1);
						apple_y <= coord_y_t'((int'(apple_y) - 1 + APPLE_STEP_Y) %
							(GRID_H - 2) + 1);
					end
				end
			end
		end
	end

	assign head_x = body_x[0];
	assign head_y = body_y[0];

endmodule

`default_nettype wire

//--- hdl/score_keeper.sv
`timescale 1ns/1ps
`default_nettype none

module score_keeper import snake_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   restart,
	input  logic   apple_eaten,
	input  logic   game_over,
	output score_t score,                         // apples this game
	output score_t best_score                     // kept across restarts
);

	logic game_over_q;                            // for edge detect

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			score       <= '0;
			best_score  <= '0;
			game_over_q <= 1'b0;
		end
		else
		begin
			game_over_q <= game_over;
			if (restart)
				score <= '0;
			else if (apple_eaten)
				score <= score + 8'd1;
			if (game_over && !game_over_q && score > best_score)
				best_score <= score;              // game just ended
		end
	end

endmodule

`default_nettype wire

//--- hdl/snake_top.sv
`timescale 1ns/1ps
`default_nettype none

module snake_top import snake_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     ps2c,                        // keyboard clock line
	input  logic     ps2d,                        // keyboard data line
	output coord_x_t head_x,
	output coord_y_t head_y,
	output dir_t     dir,
	output logic     game_over,
	output score_t   score,
	output score_t   best_score
);

	logic [7:0] rx_data;
	logic       rx_valid;
	logic       restart;
	logic       apple_eaten;

	////////////////////////////// keyboard path
	ps2_rx i_ps2_rx
	(
		.clk      (clk),
		.reset    (reset),
		.ps2c     (ps2c),
		.ps2d     (ps2d),
		.rx_data  (rx_data),
		.rx_valid (rx_valid)
	);

	key_decode i_key_decode
	(
		.clk      (clk),
		.reset    (reset),
		.rx_data  (rx_data),
		.rx_valid (rx_valid),
		.dir      (dir),
		.restart  (restart)
	);

	////////////////////////////// game core
	snake_engine i_snake_engine
	(
		.clk         (clk),
		.reset       (reset),
		.dir         (dir),
		.restart     (restart),
		.head_x      (head_x),
		.head_y      (head_y),
		.apple_eaten (apple_eaten),
		.game_over   (game_over)
	);

	score_keeper i_score_keeper
	(
		.clk         (clk),
		.reset       (reset),
		.restart     (restart),               // clears score, keeps best
		.apple_eaten (apple_eaten),
		.game_over   (game_over),
		.score       (score),
		.best_score  (best_score)
	);

endmodule

`default_nettype wire

//--- verif/tb_ps2_tasks.svh
`ifndef TB_PS2_TASKS_SVH
`define TB_PS2_TASKS_SVH

////////////////////////////// ps2 frames
// start, 8 data lsb first, odd parity, stop; data set while ps2c is high
task automatic send_frame(input logic [7:0] code);
	logic [10:0] frame;
	frame = {1'b1, ~^code, code, 1'b0};
	@(posedge clk);
	for (int i = 0; i < 11; i++)
	begin
		ps2d <= frame[i];
		repeat (PS2_HALF) @(posedge clk);
		ps2c <= 1'b0;                             // keyboard drives edge
		repeat (PS2_HALF) @(posedge clk);
		ps2c <= 1'b1;
	end
	repeat (PS2_HALF) @(posedge clk);             // idle tail, decode settles
endtask

////////////////////////////// random gaps
function automatic int unsigned xorshift32(input int unsigned s);
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

task automatic random_gap();
	rng = xorshift32(rng);
	repeat (rng % 16) @(posedge clk);             // 0..15 idle cycles
endtask

////////////////////////////// waits and checks
// returns on the first head move or game over change
task automatic wait_move();
	coord_x_t x0;
	coord_y_t y0;
	logic     go0;
	int       n;
	x0  = head_x;
	y0  = head_y;
	go0 = game_over;
	n   = 0;
	@(negedge clk);
	while (head_x == x0 && head_y == y0 && game_over == go0 && n < MOVE_TIMEOUT)
	begin
		@(negedge clk);
		n++;
	end
	if (n >= MOVE_TIMEOUT)
	begin
		$display("timeout: the head did not move within %0d cycles", MOVE_TIMEOUT);
		timeout_errors++;
		finish_run();
	end
endtask

task automatic compare_value(input string name, input int expected, input int actual);
	if (expected != actual)
	begin
		$display("ERR %s expected %0d actual %0d", name, expected, actual);
		check_errors++;
	end
endtask

`endif

//--- verif/tb_snake.sv
`timescale 1ns/1ps
`default_nettype none

module tb_snake import snake_pkg::*;;

	localparam int          PS2_HALF     = 12;             // clk per ps2c level
	localparam int          MOVE_TIMEOUT = 4 * MOVE_PERIOD;
	localparam int          MAX_MOVES    = 40;             // longest run to a wall
	localparam int unsigned SEED         = 9784;

	logic     clk = 1'b0;
	logic     reset;
	logic     ps2c;
	logic     ps2d;
	coord_x_t head_x;
	coord_y_t head_y;
	dir_t     dir;
	logic     game_over;
	score_t   score;
	score_t   best_score;

	int          check_errors   = 0;
	int          timeout_errors = 0;
	int unsigned rng;
	bit          resync;                                   // model waits for restart
	int          m_x, m_y, m_ax, m_ay, m_len, exp_score;   // reference model state
	int          t_x, t_y, t_ax, t_ay, t_len;
	bit          t_eat, t_over;
	coord_x_t    last_x;
	coord_y_t    last_y;
	logic        last_go;
	dir_t        last_dir;                                 // dir seen before the tick
	int          n;
	int          best_before;
	coord_x_t    hold_x;
	coord_y_t    hold_y;

	`include "tb_ps2_tasks.svh"

	always #20 clk = ~clk;                                 // 40 ns period

	snake_top i_dut
	(
		.clk        (clk),
		.reset      (reset),
		.ps2c       (ps2c),
		.ps2d       (ps2d),
		.head_x     (head_x),
		.head_y     (head_y),
		.dir        (dir),
		.game_over  (game_over),
		.score      (score),
		.best_score (best_score)
	);

	////////////////////////////// reference model
	// one move tick: head step, wall check, apple and growth
	function automatic void ref_step(input int hx, input int hy, input dir_t d,
		input int ax, input int ay, input int ln, output int nx, output int ny,
		output int nax, output int nay, output int nlen, output bit eat, output bit over);
		nx   = hx + ((d == DIR_RIGHT) ? 1 : (d == DIR_LEFT) ? -1 : 0);
		ny   = hy + ((d == DIR_DOWN) ? 1 : (d == DIR_UP) ? -1 : 0);
		nax  = ax;
		nay  = ay;
		nlen = ln;
		over = (nx == 0) || (nx == GRID_W - 1) || (ny == 0) || (ny == GRID_H - 1);
		eat  = !over && nx == ax && ny == ay;
		if (over)
		begin
			nx = hx;                                       // frozen at the wall
			ny = hy;
		end
		if (eat)
		begin
			nlen = (ln < MAX_LEN) ? ln + 1 : MAX_LEN;
			nax  = (ax - 1 + APPLE_STEP_X) % (GRID_W - 2) + 1;
			nay  = (ay - 1 + APPLE_STEP_Y) % (GRID_H - 2) + 1;
		end
	endfunction

	task automatic reset_model();
		m_x       = START_X;
		m_y       = START_Y;
		m_ax      = APPLE_X0;
		m_ay      = APPLE_Y0;
		m_len     = START_LEN;
		exp_score = 0;
	endtask

	task automatic finish_run();
		$display("errors: %0d value mismatches, %0d timeouts", check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	endtask

	////////////////////////////// compare process
	always @(negedge clk)
	begin
		if (reset)
			reset_model();
		else if (head_x != last_x || head_y != last_y || game_over != last_go)
		begin
			if (resync)
			begin
				if (head_x == START_X && head_y == START_Y && !game_over)
				begin
					reset_model();                         // new game started
					resync = 1'b0;
				end
			end
			else
			begin
				ref_step(m_x, m_y, last_dir, m_ax, m_ay, m_len,
					t_x, t_y, t_ax, t_ay, t_len, t_eat, t_over);
				m_x   = t_x;
				m_y   = t_y;
				m_ax  = t_ax;
				m_ay  = t_ay;
				m_len = t_len;
				if (t_eat)
					exp_score++;
				compare_value("move_head_x", m_x, head_x);
				compare_value("move_head_y", m_y, head_y);
				compare_value("move_game_over", t_over, game_over);
			end
		end
		last_x   = head_x;
		last_y   = head_y;
		last_go  = game_over;
		last_dir = dir;
	end

	task automatic send_key(input bit ext, input logic [7:0] code);
		random_gap();
		if (ext)
			send_frame(KEY_EXT);
		send_frame(code);
	endtask

	task automatic wait_game_over();
		n = 0;
		while (!game_over && n < MAX_MOVES)
		begin
			wait_move();
			n++;
		end
		if (!game_over)
		begin
			$display("timeout: the snake never reached the wall");
			timeout_errors++;
			finish_run();
		end
	endtask

	////////////////////////////// test sequence
	initial
	begin
		reset  = 1'b1;
		ps2c   = 1'b1;                                     // ps2 bus idles high
		ps2d   = 1'b1;
		resync = 1'b0;
		rng    = SEED;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		compare_value("reset_head_x", START_X, head_x);
		compare_value("reset_head_y", START_Y, head_y);
		compare_value("reset_dir", DIR_RIGHT, dir);
		compare_value("reset_game_over", 0, game_over);
		compare_value("reset_score", 0, score);
		compare_value("reset_best", 0, best_score);
		wait_move();
		wait_move();
		send_key(1'b1, KEY_LEFT);                          // reverse, ignored
		@(negedge clk);
		compare_value("reverse_dir", DIR_RIGHT, dir);
		n = 0;
		while (head_x != APPLE_X0 - 1 && n < 16)           // one column short of the apple
		begin
			wait_move();
			n++;
		end
		// an extended key spans eight ticks, so the head turns down in the next apple's column
		send_key(1'b1, KEY_DOWN);
		@(negedge clk);
		compare_value("apple_score", 1, score);
		compare_value("down_dir", DIR_DOWN, dir);
		send_key(1'b1, KEY_LEFT);                          // second apple on the way down
		@(negedge clk);
		compare_value("left_dir", DIR_LEFT, dir);
		compare_value("apple2_score", 2, score);
		random_gap();
		send_frame(KEY_BREAK);                             // release of up
		send_frame(KEY_UP);
		@(negedge clk);
		compare_value("break_dir", DIR_LEFT, dir);
		send_key(1'b1, KEY_UP);
		@(negedge clk);
		compare_value("up_dir", DIR_UP, dir);
		wait_game_over();                                  // top wall
		repeat (2) @(negedge clk);
		compare_value("end_score", exp_score, score);
		compare_value("end_best", exp_score, best_score);
		hold_x = head_x;
		hold_y = head_y;
		repeat (2 * MOVE_PERIOD) @(negedge clk);           // spans two ticks
		compare_value("frozen_head_x", hold_x, head_x);
		compare_value("frozen_head_y", hold_y, head_y);
		best_before = best_score;
		resync = 1'b1;
		send_key(1'b0, KEY_SPACE);
		n = 0;
		while (resync && n < MOVE_TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (resync)
		begin
			$display("timeout: the game did not restart after space");
			timeout_errors++;
			finish_run();
		end
		@(negedge clk);
		compare_value("restart_score", 0, score);
		compare_value("restart_game_over", 0, game_over);
		compare_value("restart_best", best_before, best_score);
		compare_value("restart_dir", DIR_RIGHT, dir);
		send_key(1'b1, KEY_DOWN);                          // dodge the apple
		@(negedge clk);
		compare_value("game2_dir", DIR_DOWN, dir);
		wait_game_over();                                  // bottom wall
		repeat (2) @(negedge clk);
		compare_value("game2_score", exp_score, score);
		compare_value("game2_best", best_before, best_score);
		finish_run();
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verif
hdl/snake_pkg.sv
hdl/ps2_rx.sv
hdl/key_decode.sv
hdl/snake_engine.sv
hdl/score_keeper.sv
hdl/snake_top.sv
verif/tb_snake.sv

//--- Bender.yml
package:
  name: snake

sources:
  - files:
      - hdl/snake_pkg.sv
      - hdl/ps2_rx.sv
      - hdl/key_decode.sv
      - hdl/snake_engine.sv
      - hdl/score_keeper.sv
      - hdl/snake_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_snake.sv
